// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       := tb_cop_top
FILELIST  := project.f
BUILD_DIR := obj_dir
PASS_MSG  := SIMULATION PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== hw/cop_decode.sv ====
/*
 * Coprocessor instruction decode stage
 * Splits the instruction word into class, subclass, register fields and
 * immediate, flags illegal encodings and registers the decoded record.
 */
`timescale 1ns/1ps

module cop_decode import cop_pkg::*; (
    input  logic                g_clk,
    input  logic                rst,
    input  logic                in_valid,
    input  logic [COP_XLEN-1:0] in_instr,
    input  logic [COP_XLEN-1:0] in_rs1_value,
    output cop_dec_s            dec
);

    cop_funct_e funct;
    cop_pw_e    pw;
    cop_class_e cls;
    logic [3:0] subclass;
    logic       opcode_ok;
    logic       funct_ok;
    logic       bad_pw;
    logic       illegal;
    logic [COP_XLEN-1:0] imm;
    cop_dec_s   nxt;

    assign funct     = cop_funct_e'(in_instr[FUNCT_MSB:FUNCT_LSB]);
    assign pw        = cop_pw_e'(in_instr[PW_MSB:PW_LSB]);
    assign opcode_ok = (in_instr[OPCODE_MSB:0] == COP_OPCODE);

    // Class and position within the class
    always_comb begin
        cls      = NONE;
        subclass = 4'd0;
        funct_ok = 1'b1;
        case (funct)
            ADD_PX: begin
                cls      = PACKED_ARITH;
                subclass = SCLASS_ADD_PX;
            end
            SUB_PX: begin
                cls      = PACKED_ARITH;
                subclass = SCLASS_SUB_PX;
            end
            SLLI_PX: begin
                cls      = PACKED_ARITH;
                subclass = SCLASS_SLLI_PX;
            end
            BOP_CR: begin
                cls      = BITWISE;
                subclass = SCLASS_BOP_CR;
            end
            GPR2XCR: begin
                cls      = MOVE;
                subclass = SCLASS_GPR2XCR;
            end
            XCR2GPR: begin
                cls      = MOVE;
                subclass = SCLASS_XCR2GPR;
            end
            CMOV_CR: begin
                cls      = MOVE;
                subclass = SCLASS_CMOV_CR;
            end
            default: funct_ok = 1'b0;    // Funct 7..15 unassigned
        endcase
    end

    // Only widths 0..2 exist for packed arithmetic
    assign bad_pw  = (cls == PACKED_ARITH) && !(pw inside {PW_32, PW_16, PW_8});
    assign illegal = !opcode_ok || !funct_ok || bad_pw;

    always_comb begin
        imm = '0;
        if (funct == SLLI_PX) begin
            imm = {27'b0, in_instr[SHAMT_MSB:CRS2_LSB]};
        end else if (funct == BOP_CR) begin
            imm = {28'b0, in_instr[LUT4_MSB:LUT4_LSB]};
        end
    end

    always_comb begin
        nxt           = '0;
        nxt.valid     = in_valid;
        nxt.exception = in_valid && illegal;
        nxt.cls       = cls;
        nxt.subclass  = subclass;
        nxt.pw        = pw;
        nxt.crs1      = in_instr[CRS1_MSB:CRS1_LSB];
        nxt.crs2      = in_instr[CRS2_MSB:CRS2_LSB];
        nxt.crd       = in_instr[CRD_MSB:CRD_LSB];
        nxt.rd        = in_instr[RD_MSB:CRD_LSB];
        nxt.imm       = imm;
        nxt.gpr       = in_rs1_value;
        nxt.cr_wen    = in_valid && !illegal && (funct != XCR2GPR);
        nxt.gpr_wen   = in_valid && !illegal && (funct == XCR2GPR);
    end

    always_ff @(posedge g_clk) begin
        if (rst) begin
            dec <= '0;
        end else begin
            dec <= nxt;
        end
    end

endmodule

// ==== hw/cop_execute.sv ====
/*
 * Coprocessor execute stage
 * Lane-wise packed add, subtract and shift, the LUT bitwise operation
 * and register moves. Drives the next writeback record combinationally
 * for bypassing and registers it as the stage output.
 */
`timescale 1ns/1ps

module cop_execute import cop_pkg::*; (
    input  logic     g_clk,
    input  logic     rst,
    input  cop_opr_s opr,
    output cop_wb_s  ex_fwd,
    output cop_wb_s  wb
);

    cop_word_u           px_res;
    logic [COP_XLEN-1:0] bop_res;
    logic [4:0]          shamt;
    cop_wb_s             nxt;

    assign shamt = opr.dec.imm[4:0];

    // Carries and shifted-out bits stay inside each lane
    always_comb begin
        px_res.w = '0;
        case (opr.dec.pw)
            PW_16: begin
                for (int i = 0; i < 2; i++) begin
                    case (opr.dec.subclass)
                        SCLASS_ADD_PX:  px_res.h[i] = opr.a.h[i] + opr.b.h[i];
                        SCLASS_SUB_PX:  px_res.h[i] = opr.a.h[i] - opr.b.h[i];
                        SCLASS_SLLI_PX: px_res.h[i] = opr.a.h[i] << shamt[3:0];
                        default: ;
                    endcase
                end
            end
            PW_8: begin
                for (int i = 0; i < 4; i++) begin
                    case (opr.dec.subclass)
                        SCLASS_ADD_PX:  px_res.b[i] = opr.a.b[i] + opr.b.b[i];
                        SCLASS_SUB_PX:  px_res.b[i] = opr.a.b[i] - opr.b.b[i];
                        SCLASS_SLLI_PX: px_res.b[i] = opr.a.b[i] << shamt[2:0];
                        default: ;
                    endcase
                end
            end
            default: begin
                case (opr.dec.subclass)
                    SCLASS_ADD_PX:  px_res.w = opr.a.w + opr.b.w;
                    SCLASS_SUB_PX:  px_res.w = opr.a.w - opr.b.w;
                    SCLASS_SLLI_PX: px_res.w = opr.a.w << shamt;
                    default: ;
                endcase
            end
        endcase
    end

    // Each result bit picks one lut4 entry by its {a, b} bit pair
    always_comb begin
        for (int i = 0; i < COP_XLEN; i++) begin
            bop_res[i] = opr.dec.imm[{opr.a.w[i], opr.b.w[i]}];
        end
    end

    always_comb begin
        nxt           = '0;
        nxt.valid     = opr.dec.valid;
        nxt.exception = opr.dec.exception;
        nxt.crd       = opr.dec.crd;
        nxt.rd        = opr.dec.rd;
        nxt.cr_wen    = opr.dec.cr_wen && !opr.dec.exception;
        nxt.gpr_wen   = opr.dec.gpr_wen && !opr.dec.exception;
        case (opr.dec.cls)
            PACKED_ARITH: nxt.cr_wdata = px_res.w;
            BITWISE: begin
                if (opr.dec.subclass == SCLASS_BOP_CR) begin
                    nxt.cr_wdata = bop_res;
                end
            end
            MOVE: begin
                case (opr.dec.subclass)
                    SCLASS_GPR2XCR: nxt.cr_wdata = opr.dec.gpr;
                    SCLASS_XCR2GPR: nxt.gpr_wdata = opr.a.w;
                    SCLASS_CMOV_CR: begin
                        nxt.cr_wdata = opr.a.w;
                        nxt.cr_wen   = nxt.cr_wen && (opr.b.w != '0); // No write on zero
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    assign ex_fwd = nxt;

    always_ff @(posedge g_clk) begin
        if (rst) begin
            wb <= '0;
        end else begin
            wb <= nxt;
        end
    end

endmodule

// ==== hw/cop_operand_stage.sv ====
/*
 * Coprocessor operand stage
 * Reads crs1 and crs2 from the register file, overrides them with
 * results still in flight and registers the operand record.
 */
`timescale 1ns/1ps

module cop_operand_stage import cop_pkg::*; (
    input  logic                g_clk,
    input  logic                rst,
    input  cop_dec_s            dec,
    output logic [CR_AW-1:0]    raddr_a,
    output logic [CR_AW-1:0]    raddr_b,
    input  logic [COP_XLEN-1:0] rdata_a,
    input  logic [COP_XLEN-1:0] rdata_b,
    input  cop_wb_s             ex_fwd,
    input  cop_wb_s             wb_fwd,
    output cop_opr_s            opr
);

    cop_opr_s nxt;

    // Youngest producer wins, then the pending write, then the array
    function automatic logic [COP_XLEN-1:0] bypass(
        input logic [CR_AW-1:0]    src,
        input logic [COP_XLEN-1:0] rf_value,
        input cop_wb_s             ex,
        input cop_wb_s             wb
    );
        logic [COP_XLEN-1:0] value;
        value = rf_value;
        if (ex.valid && ex.cr_wen && (ex.crd == src)) begin
            value = ex.cr_wdata;
        end else if (wb.valid && wb.cr_wen && (wb.crd == src)) begin
            value = wb.cr_wdata;
        end
        return value;
    endfunction

    assign raddr_a = dec.crs1;
    assign raddr_b = dec.crs2;

    always_comb begin
        nxt.dec = dec;
        nxt.a.w = bypass(dec.crs1, rdata_a, ex_fwd, wb_fwd);
        nxt.b.w = bypass(dec.crs2, rdata_b, ex_fwd, wb_fwd);
    end

    always_ff @(posedge g_clk) begin
        if (rst) begin
            opr <= '0;
        end else begin
            opr <= nxt;
        end
    end

endmodule

// ==== hw/cop_pkg.sv ====
/*
 * Coprocessor shared definitions
 * Encoding constants, instruction classes and subclasses, pack widths,
 * the lane-addressable data word and the records passed between the
 * decode, operand and writeback stages.
 */
package cop_pkg;

    localparam int COP_XLEN = 32;
    localparam int NUM_CR   = 16;
    localparam int CR_AW    = 4;

    localparam logic [6:0] COP_OPCODE = 7'b0001011; // custom-0

    // Instruction field positions
    localparam int OPCODE_MSB = 6;
    localparam int CRD_LSB    = 7;
    localparam int CRD_MSB    = 10;
    localparam int RD_MSB     = 11;  // rd shares the crd LSB
    localparam int CRS1_LSB   = 15;
    localparam int CRS1_MSB   = 18;
    localparam int CRS2_LSB   = 20;
    localparam int CRS2_MSB   = 23;
    localparam int SHAMT_MSB  = 24;  // shamt starts at CRS2_LSB
    localparam int LUT4_LSB   = 24;
    localparam int LUT4_MSB   = 27;
    localparam int PW_LSB     = 25;
    localparam int PW_MSB     = 27;
    localparam int FUNCT_LSB  = 28;
    localparam int FUNCT_MSB  = 31;

    typedef enum logic [3:0] {
        ADD_PX  = 4'd0,
        SUB_PX  = 4'd1,
        SLLI_PX = 4'd2,
        BOP_CR  = 4'd3,
        GPR2XCR = 4'd4,
        XCR2GPR = 4'd5,
        CMOV_CR = 4'd6
    } cop_funct_e;

    typedef enum logic [2:0] {
        NONE         = 3'd0,
        PACKED_ARITH = 3'd1,
        BITWISE      = 3'd2,
        MOVE         = 3'd3
    } cop_class_e;

    typedef enum logic [2:0] {
        PW_32 = 3'd0,
        PW_16 = 3'd1,
        PW_8  = 3'd2
    } cop_pw_e;

    // Position of each operation inside its class
    localparam logic [3:0] SCLASS_ADD_PX  = 4'd0;
    localparam logic [3:0] SCLASS_SUB_PX  = 4'd1;
    localparam logic [3:0] SCLASS_SLLI_PX = 4'd2;
    localparam logic [3:0] SCLASS_BOP_CR  = 4'd0;
    localparam logic [3:0] SCLASS_GPR2XCR = 4'd0;
    localparam logic [3:0] SCLASS_XCR2GPR = 4'd1;
    localparam logic [3:0] SCLASS_CMOV_CR = 4'd2;

    // One coprocessor word seen as 1x32, 2x16 or 4x8 lanes
    typedef union packed {
        logic [COP_XLEN-1:0] w;
        logic [1:0][15:0]    h;
        logic [3:0][7:0]     b;
    } cop_word_u;

    typedef struct packed {
        logic                valid;
        logic                exception;
        cop_class_e          cls;
        logic [3:0]          subclass;
        cop_pw_e             pw;
        logic [CR_AW-1:0]    crs1;
        logic [CR_AW-1:0]    crs2;
        logic [CR_AW-1:0]    crd;
        logic [4:0]          rd;
        logic [COP_XLEN-1:0] imm;
        logic [COP_XLEN-1:0] gpr;     // Host value of GPR rs1
        logic                cr_wen;
        logic                gpr_wen;
    } cop_dec_s;

    typedef struct packed {
        cop_dec_s  dec;
        cop_word_u a;
        cop_word_u b;
    } cop_opr_s;

    typedef struct packed {
        logic                valid;
        logic                exception;
        logic                cr_wen;
        logic [CR_AW-1:0]    crd;
        logic [COP_XLEN-1:0] cr_wdata;
        logic                gpr_wen;
        logic [4:0]          rd;
        logic [COP_XLEN-1:0] gpr_wdata;
    } cop_wb_s;

endpackage

// ==== hw/cop_regfile.sv ====
/*
 * Coprocessor register file
 * Sixteen 32-bit registers, two asynchronous read ports and one
 * synchronous write port.
 */
`timescale 1ns/1ps

module cop_regfile import cop_pkg::*; (
    input  logic                g_clk,
    input  logic                rst,
    input  logic [CR_AW-1:0]    raddr_a,
    input  logic [CR_AW-1:0]    raddr_b,
    output logic [COP_XLEN-1:0] rdata_a,
    output logic [COP_XLEN-1:0] rdata_b,
    input  logic                wen,
    input  logic [CR_AW-1:0]    waddr,
    input  logic [COP_XLEN-1:0] wdata
);

    logic [COP_XLEN-1:0] regs [NUM_CR];

    // Read-before-write; the operand stage bypasses the pending write
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

    always_ff @(posedge g_clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_CR; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[waddr] <= wdata;
        end
    end

endmodule

// ==== hw/cop_top.sv ====
/*
 * Coprocessor pipeline top level
 * Decode, operand and execute stages around the register file, giving
 * a result three cycles after each issued instruction.
 */
`timescale 1ns/1ps

module cop_top import cop_pkg::*; (
    input  logic                g_clk,
    input  logic                rst,
    input  logic                in_valid,
    input  logic [COP_XLEN-1:0] in_instr,
    input  logic [COP_XLEN-1:0] in_rs1_value,
    output logic                res_valid,
    output logic                res_exception,
    output logic                cr_wen,
    output logic [CR_AW-1:0]    cr_addr,
    output logic [COP_XLEN-1:0] cr_wdata,
    output logic                gpr_wen,
    output logic [4:0]          gpr_rd,
    output logic [COP_XLEN-1:0] gpr_wdata
);

    cop_dec_s            dec;
    cop_opr_s            opr;
    cop_wb_s             ex_fwd;
    cop_wb_s             wb;
    logic [CR_AW-1:0]    raddr_a;
    logic [CR_AW-1:0]    raddr_b;
    logic [COP_XLEN-1:0] rdata_a;
    logic [COP_XLEN-1:0] rdata_b;

    cop_decode u_decode (
        .g_clk        (g_clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_instr     (in_instr),
        .in_rs1_value (in_rs1_value),
        .dec          (dec)
    );

    cop_operand_stage u_operand (
        .g_clk   (g_clk),
        .rst     (rst),
        .dec     (dec),
        .raddr_a (raddr_a),
        .raddr_b (raddr_b),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .ex_fwd  (ex_fwd),
        .wb_fwd  (wb),
        .opr     (opr)
    );

    // Written one edge after the result leaves the pipeline
    cop_regfile u_regfile (
        .g_clk   (g_clk),
        .rst     (rst),
        .raddr_a (raddr_a),
        .raddr_b (raddr_b),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .wen     (wb.valid && wb.cr_wen),
        .waddr   (wb.crd),
        .wdata   (wb.cr_wdata)
    );

    cop_execute u_execute (
        .g_clk  (g_clk),
        .rst    (rst),
        .opr    (opr),
        .ex_fwd (ex_fwd),
        .wb     (wb)
    );

    assign res_valid     = wb.valid;
    assign res_exception = wb.exception;
    assign cr_wen        = wb.cr_wen;
    assign cr_addr       = wb.crd;
    assign cr_wdata      = wb.cr_wdata;
    assign gpr_wen       = wb.gpr_wen;
    assign gpr_rd        = wb.rd;
    assign gpr_wdata     = wb.gpr_wdata;

endmodule

// ==== project.f ====
hw/cop_pkg.sv
hw/cop_decode.sv
hw/cop_regfile.sv
hw/cop_operand_stage.sv
hw/cop_execute.sv
hw/cop_top.sv
verification/tb_cop_top.sv

// ==== verification/tb_cop_top.sv ====
/*
 * Testbench for the coprocessor pipeline
 * Keeps a register model and a queue of expected writeback records,
 * and checks every result with assertions.
 */
`timescale 1ns/1ps

module tb_cop_top import cop_pkg::*; ();

    localparam int PX_REPS     = 4;
    localparam int DEP_LEN     = 16;
    localparam int RAND_LEN    = 200;
    localparam int IDLE_CYCLES = 5;
    localparam int NUM_TESTS   = 6;
    localparam int DRAIN_SLACK = 10;  // Pipeline drain per test
    localparam int TOTAL_INSTR = 2 * NUM_CR + 27 * PX_REPS + 26 + (DEP_LEN + 8)
                               + (28 + NUM_CR) + (RAND_LEN + NUM_CR);
    localparam int WATCHDOG_CYCLES = TOTAL_INSTR + 20 + NUM_TESTS * DRAIN_SLACK + IDLE_CYCLES + 2;

    logic        g_clk;
    logic        rst;
    logic        in_valid;
    logic [31:0] in_instr;
    logic [31:0] in_rs1_value;
    logic        res_valid;
    logic        res_exception;
    logic        cr_wen;
    logic [3:0]  cr_addr;
    logic [31:0] cr_wdata;
    logic        gpr_wen;
    logic [4:0]  gpr_rd;
    logic [31:0] gpr_wdata;

    integer      seed = 32'h2a60_2d33;
    logic [31:0] model_cr [NUM_CR];
    cop_wb_s     expected_q [$];
    cop_wb_s     head;
    int          issued;
    int          results;
    int          checks;
    int          check_errors;
    int          latency_errors;
    int          errors_before;
    int          test_count;

    cop_top u_dut (
        .g_clk         (g_clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .in_instr      (in_instr),
        .in_rs1_value  (in_rs1_value),
        .res_valid     (res_valid),
        .res_exception (res_exception),
        .cr_wen        (cr_wen),
        .cr_addr       (cr_addr),
        .cr_wdata      (cr_wdata),
        .gpr_wen       (gpr_wen),
        .gpr_rd        (gpr_rd),
        .gpr_wdata     (gpr_wdata)
    );

    always #5 g_clk = ~g_clk;

    function automatic logic [31:0] rnd();
        return $random(seed);
    endfunction

    // funct | lut4 or {pw, shamt[4]} | crs2 | crs1 | rd | opcode
    function automatic logic [31:0] encode(input logic [3:0] funct, input logic [3:0] mid,
                                           input logic [3:0] crs2, input logic [3:0] crs1,
                                           input logic [4:0] rd);
        return {funct, mid, crs2, 1'b0, crs1, 3'b000, rd, COP_OPCODE};
    endfunction

    // Lane by lane at lane_w bits with no carry between lanes
    function automatic logic [31:0] lanewise(input logic [3:0] op, input int lane_w,
                                             input logic [31:0] a, input logic [31:0] b,
                                             input logic [4:0] shamt);
        logic [63:0] mask;
        logic [63:0] la;
        logic [63:0] lb;
        logic [63:0] r;
        logic [31:0] res;
        res  = '0;
        mask = (64'd1 << lane_w) - 64'd1;
        for (int base = 0; base < 32; base += lane_w) begin
            la = ({32'd0, a} >> base) & mask;
            lb = ({32'd0, b} >> base) & mask;
            if (op == ADD_PX) r = la + lb;
            else if (op == SUB_PX) r = la - lb;
            else r = la << (int'(shamt) % lane_w);
            res = res | 32'((r & mask) << base);
        end
        return res;
    endfunction

    // Sequential model updated at issue
    function automatic cop_wb_s predict(input logic [31:0] instr, input logic [31:0] gpr);
        cop_wb_s     exp;
        logic [3:0]  funct;
        logic [31:0] a;
        logic [31:0] b;
        int          lane_w;
        funct         = instr[31:28];
        a             = model_cr[instr[18:15]];
        b             = model_cr[instr[23:20]];
        lane_w        = (instr[27:25] == 3'd0) ? 32 : (instr[27:25] == 3'd1) ? 16 : 8;
        exp           = '0;
        exp.valid     = 1'b1;
        exp.crd       = instr[10:7];
        exp.rd        = instr[11:7];
        exp.exception = (instr[6:0] != COP_OPCODE) || (funct > 4'd6)
                        || (funct <= 4'd2 && instr[27:25] > 3'd2);
        if (!exp.exception) begin
            exp.cr_wen = 1'b1;
            case (funct)
                ADD_PX, SUB_PX, SLLI_PX: begin
                    exp.cr_wdata = lanewise(funct, lane_w, a, b, instr[24:20]);
                end
                BOP_CR: begin
                    for (int i = 0; i < 32; i++) exp.cr_wdata[i] = instr[24 + {a[i], b[i]}];
                end
                GPR2XCR: exp.cr_wdata = gpr;
                XCR2GPR: begin
                    exp.cr_wen    = 1'b0;
                    exp.gpr_wen   = 1'b1;
                    exp.gpr_wdata = a;
                end
                default: begin
                    exp.cr_wen   = (b != 32'd0);  // CMOV_CR
                    exp.cr_wdata = a;
                end
            endcase
            if (exp.cr_wen) model_cr[exp.crd] = exp.cr_wdata;
        end
        return exp;
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            $display("Mismatch at %0t: %s expected %h, actual %h", $time, name, exp, act);
            check_errors++;
        end
    endtask

    // Each result against the head of the queue
    always @(negedge g_clk) begin
        if (!rst && res_valid) begin
            results++;
            if (expected_q.size() == 0) begin
                $display("Error at %0t: result appeared with no instruction outstanding", $time);
                check_errors++;
            end else begin
                head = expected_q.pop_front();
                compare("res_exception", 32'(head.exception), 32'(res_exception));
                compare("cr_wen", 32'(head.cr_wen), 32'(cr_wen));
                compare("gpr_wen", 32'(head.gpr_wen), 32'(gpr_wen));
                if (head.cr_wen) begin
                    compare("cr_addr", 32'(head.crd), 32'(cr_addr));
                    compare("cr_wdata", head.cr_wdata, cr_wdata);
                end
                if (head.gpr_wen) begin
                    compare("gpr_rd", 32'(head.rd), 32'(gpr_rd));
                    compare("gpr_wdata", head.gpr_wdata, gpr_wdata);
                end
            end
        end else if (!rst) begin
            assert (!cr_wen && !gpr_wen && !res_exception) else begin
                $display("Error at %0t: write enable or exception set without res_valid", $time);
                check_errors++;
            end
        end
    end

    assert property (@(posedge g_clk) disable iff (rst) res_valid == $past(in_valid, 3))
        else begin
            $display("Error at %0t: res_valid did not follow in_valid by 3 cycles", $time);
            latency_errors++;
        end

    task automatic issue(input logic [31:0] instr, input logic [31:0] gpr);
        @(posedge g_clk);
        in_valid     <= 1'b1;
        in_instr     <= instr;
        in_rs1_value <= gpr;
        expected_q.push_back(predict(instr, gpr));
        issued++;
    endtask

    task automatic load(input logic [3:0] crd, input logic [31:0] value);
        issue(encode(GPR2XCR, 4'd0, 4'd0, 4'd0, {1'b0, crd}), value);
    endtask

    task automatic read_cr(input logic [3:0] crs1, input logic [4:0] rd);
        issue(encode(XCR2GPR, 4'd0, 4'd0, crs1, rd), rnd());
    endtask

    task automatic end_test(input string name);
        @(posedge g_clk);
        in_valid <= 1'b0;
        while (expected_q.size() != 0) @(posedge g_clk);
        repeat (2) @(posedge g_clk);
        $display("Test %s done, %0d new errors", name,
                 check_errors + latency_errors - errors_before);
        errors_before = check_errors + latency_errors;
        test_count++;
    endtask

    task automatic packed_arith_ops();
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  shamt;
        for (int op = 0; op < 3; op++) begin
            for (int pw = 0; pw < 3; pw++) begin
                for (int rep = 0; rep < PX_REPS; rep++) begin
                    a     = (rep == 0) ? 32'h00ff_ffff : rnd();  // Carry and borrow at every lane
                    b     = (rep == 0) ? 32'h0101_0101 : rnd();
                    shamt = 5'(rnd());
                    load(4'd1, a);
                    load(4'd2, b);
                    issue(encode(4'(op), {3'(pw), shamt[4]}, (op == 2) ? shamt[3:0] : 4'd2,
                                 4'd1, 5'd3), 32'd0);
                end
            end
        end
        end_test("packed");
    endtask

    task automatic bop_and_cmov();
        load(4'd1, rnd());
        load(4'd2, rnd());
        for (int lut = 0; lut < 16; lut++) begin
            issue(encode(BOP_CR, 4'(lut), 4'd2, 4'd1, 5'(3 + lut % 4)), 32'd0);
        end
        load(4'd4, rnd());
        load(4'd5, 32'd0);
        load(4'd6, rnd() | 32'd1);
        load(4'd7, 32'h1234_5678);
        issue(encode(CMOV_CR, 4'd0, 4'd5, 4'd4, 5'd7), 32'd0);  // Zero condition
        read_cr(4'd7, 5'd17);
        issue(encode(CMOV_CR, 4'd0, 4'd6, 4'd4, 5'd7), 32'd0);
        read_cr(4'd7, 5'd18);
        end_test("bop_cmov");
    endtask

    // Each op reads the previous result on crs1 and the one before on crs2
    task automatic dependent_chain();
        logic [3:0]  prev1;
        logic [3:0]  prev2;
        logic [3:0]  crd;
        logic [31:0] r;
        prev1 = 4'd7;
        prev2 = 4'd6;
        for (int i = 4; i < 8; i++) load(4'(i), rnd());
        for (int k = 0; k < DEP_LEN; k++) begin
            r   = rnd();
            crd = 4'(4 + k % 4);
            issue(encode(4'(r[7:0] % 4), {3'(r[15:8] % 3), r[16]}, prev2, prev1, {1'b0, crd}),
                  32'd0);
            prev2 = prev1;
            prev1 = crd;
        end
        for (int i = 4; i < 8; i++) read_cr(4'(i), 5'(i));
        end_test("bypass");
    endtask

    task automatic illegal_encodings();
        logic [31:0] instr;
        logic [31:0] r;
        for (int k = 0; k < 4; k++) begin
            r          = rnd();
            instr      = encode(ADD_PX, 4'd0, r[11:8], r[15:12], r[20:16]);
            instr[6:0] = COP_OPCODE ^ (r[6:0] | 7'h01);
            issue(instr, rnd());
        end
        for (int f = 7; f < 16; f++) begin
            r = rnd();
            issue(encode(4'(f), r[3:0], r[7:4], r[11:8], r[16:12]), rnd());
        end
        for (int op = 0; op < 3; op++) begin
            for (int pw = 3; pw < 8; pw++) begin
                r = rnd();
                issue(encode(4'(op), {3'(pw), r[0]}, r[7:4], r[11:8], r[16:12]), rnd());
            end
        end
        for (int i = 0; i < NUM_CR; i++) read_cr(4'(i), 5'(i));
        end_test("illegal");
    endtask

    task automatic random_stream();
        logic [31:0] sel;
        logic [31:0] instr;
        for (int k = 0; k < RAND_LEN; k++) begin
            sel   = rnd();
            instr = rnd();
            if (sel[2:0] != 3'd0) instr[31:28] = 4'(rnd() % 7);  // Mostly legal funct
            if (sel[5:3] != 3'd0 && instr[31:28] <= 4'd2) instr[27:25] = 3'(rnd() % 3);
            if (sel[8:6] != 3'd0) instr[6:0] = COP_OPCODE;
            issue(instr, rnd());
        end
        for (int i = 0; i < NUM_CR; i++) read_cr(4'(i), 5'(rnd()));
        end_test("random");
    endtask

    initial begin
        g_clk        = 1'b0;
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_instr     = 32'd0;
        in_rs1_value = 32'd0;
        for (int i = 0; i < NUM_CR; i++) model_cr[i] = 32'd0;
        repeat (2) @(posedge g_clk);
        rst <= 1'b0;
        repeat (IDLE_CYCLES) @(posedge g_clk);  // Outputs must stay quiet
        for (int i = 0; i < NUM_CR; i++) load(4'(i), rnd());
        for (int i = 0; i < NUM_CR; i++) read_cr(4'(i), 5'(rnd()));
        end_test("moves");
        packed_arith_ops();
        bop_and_cmov();
        dependent_chain();
        illegal_encodings();
        random_stream();
        if (results != issued) begin
            $display("Error: %0d instructions issued but %0d results seen", issued, results);
        end
        $display("Tests: %0d, instructions: %0d, checks: %0d, errors: %0d",
                 test_count, issued, checks, check_errors + latency_errors);
        if (check_errors == 0 && latency_errors == 0 && results == issued) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("Error: run did not complete within %0d cycles", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule
